//--- vlog.f
design/idct_pkg.sv
design/dp_ram.sv
design/block_fetch.sv
design/matrix_pass.sv
design/block_store.sv
design/idct_top.sv
testbench/idct_asserts.sv
testbench/tb_idct.sv

//--- testbench/tb_idct.sv
// directed testbench for idct_top with SRAM model, reference IDCT, compare tasks and watchdog
`timescale 1ns/10ps

module tb_idct import idct_pkg::*; ();

localparam int CLK_PERIOD = 100;
localparam int NUM_BLOCKS = 6;
localparam int WATCHDOG_CYCLES = 64 * NUM_BLOCKS * 50;
localparam int DONE_LIMIT = 4000;

logic Clock = 1'b0;
logic Resetn;
logic start_i;
block_col_t block_col_i;
block_row_t block_row_i;
sram_addr_t sram_address_o;
sram_word_t sram_read_data_i;
sram_word_t sram_write_data_o;
logic sram_we_n_o;
logic busy_o;
logic done_o;

sram_word_t sram [2**18];
sram_word_t rd_stage1;
sram_word_t rd_stage2;
sram_addr_t write_addrs [$];
int coef_blk [64];
pixel_t ref_pix [64];

idct_top DUT (
	.Clock(Clock), .Resetn(Resetn), .start_i(start_i),
	.block_col_i(block_col_i), .block_row_i(block_row_i),
	.sram_address_o(sram_address_o), .sram_read_data_i(sram_read_data_i),
	.sram_write_data_o(sram_write_data_o), .sram_we_n_o(sram_we_n_o),
	.busy_o(busy_o), .done_o(done_o)
);

initial begin
	forever #(CLK_PERIOD / 2) Clock = ~Clock;
end

// SRAM model with two cycles from address to data at the DUT's sampling edge
always @(negedge Clock) begin
	if (sram_we_n_o === 1'b0) begin
		sram[sram_address_o] = sram_write_data_o;
		write_addrs.push_back(sram_address_o);
	end
	sram_read_data_i = rd_stage2;
	rd_stage2 = rd_stage1;
	rd_stage1 = sram[sram_address_o];
end

task automatic stop_run(input string why);
	$display("%s", why);
	$display("Simulation failed");
	$fatal(1, "run stopped at first error");
endtask

always @(negedge Clock) begin
	if (Resetn === 1'b1 && DUT.u_asserts.assert_errors != 0) begin
		stop_run("a protocol assertion on idct_top failed");
	end
end

initial begin
	repeat (WATCHDOG_CYCLES) @(posedge Clock);
	stop_run("watchdog expired before the tests completed");
end

task automatic check_word(input string name, input sram_word_t got, input sram_word_t exp);
	if (got !== exp) begin
		stop_run($sformatf("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, exp));
	end
endtask

task automatic check_addr(input string name, input sram_addr_t got, input sram_addr_t exp);
	if (got !== exp) begin
		stop_run($sformatf("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, exp));
	end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
	if (got !== exp) begin
		stop_run($sformatf("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, exp));
	end
endtask

// background pattern over the whole address
function automatic sram_word_t fill_value(input int addr);
	return sram_word_t'((addr * 40503) ^ (addr >> 2));
endfunction

function automatic int out_addr(input int col, input int row, input int r, input int cp);
	return int'(OUT_BASE) + (8 * row + r) * int'(OUT_ROW_STRIDE) + 4 * col + cp;
endfunction

// T = S'C >> 8, then S = C^T T >> 16 clipped to a byte
task automatic compute_reference();
	longint t [64];
	longint acc;
	longint s;
	for (int r = 0; r < 8; r++) begin
		for (int c = 0; c < 8; c++) begin
			acc = 0;
			for (int k = 0; k < 8; k++) begin
				acc += longint'(coef_blk[8*r+k]) * longint'(COS_TABLE[8*k+c]);
			end
			t[8*r+c] = acc >>> T_SHIFT;
		end
	end
	for (int r = 0; r < 8; r++) begin
		for (int c = 0; c < 8; c++) begin
			acc = 0;
			for (int k = 0; k < 8; k++) begin
				acc += longint'(COS_TABLE[8*k+r]) * t[8*k+c];
			end
			s = acc >>> S_SHIFT;
			ref_pix[8*r+c] = (s < 0) ? 8'd0 : (s > 255) ? 8'd255 : pixel_t'(s);
		end
	end
endtask

task automatic load_block(input int col, input int row);
	int addr;
	for (int r = 0; r < 8; r++) begin
		for (int c = 0; c < 8; c++) begin
			addr = int'(PRE_IDCT_BASE) + (8 * row + r) * int'(PRE_ROW_STRIDE) + 8 * col + c;
			sram[addr] = sram_word_t'(coef_blk[8*r+c]);
		end
	end
	compute_reference();
endtask

task automatic random_coeffs(input int span);
	for (int i = 0; i < 64; i++) begin
		coef_blk[i] = int'($urandom_range(2 * span)) - span;
	end
endtask

// called just after a falling edge
task automatic start_block(input int col, input int row);
	write_addrs.delete();
	block_col_i = block_col_t'(col);
	block_row_i = block_row_t'(row);
	start_i = 1'b1;
	@(negedge Clock);
	start_i = 1'b0;
	check_bit("busy_o", busy_o, 1'b1);
endtask

task automatic finish_block(input int col, input int row);
	int cycles;
	cycles = 0;
	while (done_o !== 1'b1) begin
		@(negedge Clock);
		cycles++;
		if (cycles > DONE_LIMIT) begin
			stop_run("done_o never arrived after the start pulse");
		end
	end
	check_bit("busy_o", busy_o, 1'b1);
	if (write_addrs.size() != 32) begin
		stop_run($sformatf("expected 32 SRAM writes per block, saw %0d", write_addrs.size()));
	end
	for (int i = 0; i < 32; i++) begin
		check_addr("sram_address_o", write_addrs[i],
			sram_addr_t'(out_addr(col, row, i / 4, i % 4)));
	end
	@(negedge Clock);
	check_bit("done_o", done_o, 1'b0);
	check_bit("busy_o", busy_o, 1'b0);
endtask

// even column in the upper byte
task automatic check_pixels(input int col, input int row);
	int addr;
	for (int r = 0; r < 8; r++) begin
		for (int cp = 0; cp < 4; cp++) begin
			addr = out_addr(col, row, r, cp);
			check_word($sformatf("sram[%0d]", addr), sram[addr],
				{ref_pix[8*r+2*cp], ref_pix[8*r+2*cp+1]});
		end
	end
endtask

task automatic check_untouched(input int col, input int row);
	int addr;
	for (int r = -1; r <= 8; r++) begin
		for (int cp = -1; cp <= 4; cp++) begin
			if (r < 0 || r > 7 || cp < 0 || cp > 3) begin
				addr = out_addr(col, row, r, cp);
				// no neighbour before address 0 at the image corner
				if (addr >= 0) begin
					check_word($sformatf("sram[%0d]", addr), sram[addr], fill_value(addr));
				end
			end
		end
	end
endtask

task automatic test_reset();
	Resetn = 1'b0;
	repeat (2) @(negedge Clock);
	check_bit("sram_we_n_o", sram_we_n_o, 1'b1);
	Resetn = 1'b1;
	@(negedge Clock);
	check_bit("sram_we_n_o", sram_we_n_o, 1'b1);
	check_bit("busy_o", busy_o, 1'b0);
	check_bit("done_o", done_o, 1'b0);
endtask

task automatic test_dc_block();
	coef_blk = '{default: 0};
	coef_blk[0] = 200;
	load_block(0, 0);
	start_block(0, 0);
	finish_block(0, 0);
	check_pixels(0, 0);
endtask

task automatic test_random_block(input int col, input int row);
	random_coeffs(512);
	load_block(col, row);
	start_block(col, row);
	finish_block(col, row);
	check_pixels(col, row);
	check_untouched(col, row);
endtask

task automatic test_clipping();
	int n_high;
	int n_low;
	random_coeffs(64);
	coef_blk[9] = 20000;
	load_block(39, 29);
	n_high = 0;
	n_low = 0;
	foreach (ref_pix[i]) begin
		n_high += (ref_pix[i] == 8'd255);
		n_low += (ref_pix[i] == 8'd0);
	end
	if (n_high == 0 || n_low == 0) begin
		stop_run("clipping block does not saturate in both directions");
	end
	start_block(39, 29);
	finish_block(39, 29);
	check_pixels(39, 29);
endtask

task automatic test_back_to_back();
	int ignored_addr;
	ignored_addr = out_addr(20, 20, 0, 0);
	random_coeffs(512);
	load_block(12, 2);
	start_block(12, 2);
	repeat (100) @(negedge Clock);
	// a start while busy must not redirect or queue a block
	block_col_i = 6'd20;
	block_row_i = 5'd20;
	start_i = 1'b1;
	@(negedge Clock);
	start_i = 1'b0;
	finish_block(12, 2);
	check_pixels(12, 2);
	check_word("sram[out(20,20)]", sram[ignored_addr], fill_value(ignored_addr));
	random_coeffs(512);
	load_block(13, 2);
	start_block(13, 2);
	finish_block(13, 2);
	check_pixels(13, 2);
endtask

initial begin
	Resetn = 1'b0;
	start_i = 1'b0;
	block_col_i = '0;
	block_row_i = '0;
	sram_read_data_i = '0;
	rd_stage1 = '0;
	rd_stage2 = '0;
	void'($urandom(25));
	for (int a = 0; a < 2**18; a++) begin
		sram[a] = fill_value(a);
	end
	test_reset();
	test_dc_block();
	test_random_block(0, 0);
	test_random_block(17, 9);
	test_clipping();
	test_back_to_back();
	if (DUT.u_asserts.assert_errors == 0) begin
		$display("Simulation passed");
		$finish;
	end else begin
		stop_run("protocol assertions reported errors during the run");
	end
end

endmodule

//--- testbench/idct_asserts.sv
// protocol assertions for idct_top, attached to the top level by the bind at the end of this file
`timescale 1ns/10ps

module idct_asserts import idct_pkg::*; (
	input logic       Clock,
	input logic       Resetn,
	input logic       busy_o,
	input logic       done_o,
	input logic       sram_we_n_o,
	input sram_addr_t sram_address_o,
	input top_state_t state
);

// polled by the testbench
int assert_errors = 0;

done_one_cycle: assert property (@(posedge Clock) disable iff (!Resetn)
	done_o |=> !done_o)
	else begin
		$error("done_o held for more than one cycle");
		assert_errors++;
	end

busy_until_done: assert property (@(posedge Clock) disable iff (!Resetn)
	(busy_o && !done_o) |=> busy_o)
	else begin
		$error("busy_o dropped before done_o");
		assert_errors++;
	end

// output region only, and only while storing
write_in_store: assert property (@(posedge Clock) disable iff (!Resetn)
	!sram_we_n_o |-> (state == STORE && sram_address_o < PRE_IDCT_BASE))
	else begin
		$error("SRAM write outside STORE or into the coefficient region");
		assert_errors++;
	end

endmodule

bind idct_top idct_asserts u_asserts (
	.Clock(Clock), .Resetn(Resetn), .busy_o(busy_o), .done_o(done_o),
	.sram_we_n_o(sram_we_n_o), .sram_address_o(sram_address_o), .state(state)
);

//--- design/idct_top.sv
// single-block IDCT engine top, sequences fetch, two matrix passes and store on a start pulse
`timescale 1ns/10ps

module idct_top import idct_pkg::*; (
	input  logic       Clock,
	input  logic       Resetn,
	input  logic       start_i,
	input  block_col_t block_col_i,
	input  block_row_t block_row_i,

	output sram_addr_t sram_address_o,
	input  sram_word_t sram_read_data_i,
	output sram_word_t sram_write_data_o,
	output logic       sram_we_n_o,

	output logic       busy_o,
	output logic       done_o
);

top_state_t state;
block_col_t col_q;
block_row_t row_q;

logic fetch_go;
logic pass_go;
logic store_go;
logic fetch_fin;
logic pass_fin;
logic store_fin;

sram_addr_t fetch_sram_addr;
buf_addr_t fetch_buf_addr;
buf_word_t fetch_buf_wdata;
logic fetch_buf_we;

buf_addr_t mp_rd_addr;
buf_word_t mp_rd_data;
buf_addr_t mp_wr_addr;
buf_word_t mp_wr_data;
logic mp_wr_en;

buf_addr_t st_addr_a;
buf_addr_t st_addr_b;
sram_addr_t st_sram_addr;
sram_word_t st_sram_data;
logic st_we_n;

buf_addr_t buf0_addr_a;
buf_word_t buf0_wdata_a;
logic buf0_we_a;
buf_word_t buf0_rdata_a;
buf_word_t buf0_rdata_b;
logic buf1_we_a;
buf_word_t buf1_rdata_b;

always_ff @(posedge Clock or negedge Resetn) begin
	if (!Resetn) begin
		state <= IDLE;
		fetch_go <= 1'b0;
		pass_go <= 1'b0;
		store_go <= 1'b0;
	end else begin
		fetch_go <= 1'b0;
		pass_go <= 1'b0;
		store_go <= 1'b0;
		case (state)
			IDLE: begin
				if (start_i) begin
					fetch_go <= 1'b1;
					state <= FETCH;
				end
			end
			FETCH: begin
				if (fetch_fin) begin
					pass_go <= 1'b1;
					state <= PASS_T;
				end
			end
			PASS_T: begin
				if (pass_fin) begin
					pass_go <= 1'b1;
					state <= PASS_S;
				end
			end
			PASS_S: begin
				if (pass_fin) begin
					store_go <= 1'b1;
					state <= STORE;
				end
			end
			STORE: begin
				if (store_fin) begin
					state <= IDLE;
				end
			end
			default: state <= IDLE;
		endcase
	end
end

// position held for the whole block
always_ff @(posedge Clock) begin
	if (state == IDLE && start_i) begin
		col_q <= block_col_i;
		row_q <= block_row_i;
	end
end

assign busy_o = (state != IDLE);
assign done_o = (state == STORE) && store_fin;

// buffer 0 port A changes owner every phase
always_comb begin
	buf0_addr_a = mp_rd_addr;
	buf0_wdata_a = mp_wr_data;
	buf0_we_a = 1'b0;
	case (state)
		FETCH: begin
			buf0_addr_a = fetch_buf_addr;
			buf0_wdata_a = fetch_buf_wdata;
			buf0_we_a = fetch_buf_we;
		end
		PASS_S: begin
			buf0_addr_a = mp_wr_addr;
			buf0_we_a = mp_wr_en;
		end
		STORE: buf0_addr_a = st_addr_a;
		default: buf0_addr_a = mp_rd_addr;
	endcase
end

assign buf1_we_a = mp_wr_en && (state == PASS_T);
assign mp_rd_data = (state == PASS_S) ? buf1_rdata_b : buf0_rdata_a;

assign sram_address_o = (state == STORE) ? st_sram_addr : fetch_sram_addr;
assign sram_write_data_o = (state == STORE) ? st_sram_data : '0;
assign sram_we_n_o = (state == STORE) ? st_we_n : 1'b1;

dp_ram buf0 (
	.Clock(Clock),
	.addr_a_i(buf0_addr_a), .wdata_a_i(buf0_wdata_a), .we_a_i(buf0_we_a),
	.rdata_a_o(buf0_rdata_a),
	.addr_b_i(st_addr_b), .wdata_b_i('0), .we_b_i(1'b0),
	.rdata_b_o(buf0_rdata_b)
);

// T lands on port A, read back on port B
dp_ram buf1 (
	.Clock(Clock),
	.addr_a_i(mp_wr_addr), .wdata_a_i(mp_wr_data), .we_a_i(buf1_we_a),
	.rdata_a_o(),
	.addr_b_i(mp_rd_addr), .wdata_b_i('0), .we_b_i(1'b0),
	.rdata_b_o(buf1_rdata_b)
);

block_fetch u_fetch (
	.Clock(Clock), .Resetn(Resetn), .go_i(fetch_go),
	.block_col_i(col_q), .block_row_i(row_q),
	.sram_address_o(fetch_sram_addr), .sram_read_data_i(sram_read_data_i),
	.buf_addr_o(fetch_buf_addr), .buf_wdata_o(fetch_buf_wdata), .buf_we_o(fetch_buf_we),
	.finished_o(fetch_fin)
);

matrix_pass u_pass (
	.Clock(Clock), .Resetn(Resetn), .go_i(pass_go), .pass_s_i(state == PASS_S),
	.rd_addr_o(mp_rd_addr), .rd_data_i(mp_rd_data),
	.wr_addr_o(mp_wr_addr), .wr_data_o(mp_wr_data), .wr_en_o(mp_wr_en),
	.finished_o(pass_fin)
);

block_store u_store (
	.Clock(Clock), .Resetn(Resetn), .go_i(store_go),
	.block_col_i(col_q), .block_row_i(row_q),
	.buf_addr_a_o(st_addr_a), .buf_addr_b_o(st_addr_b),
	.buf_rdata_a_i(buf0_rdata_a), .buf_rdata_b_i(buf0_rdata_b),
	.sram_address_o(st_sram_addr), .sram_write_data_o(st_sram_data),
	.sram_we_n_o(st_we_n), .finished_o(store_fin)
);

endmodule

//--- design/block_store.sv
// reads final pixels from buffer 0 in pairs, packs them even-high and writes them to SRAM
`timescale 1ns/10ps

module block_store import idct_pkg::*; (
	input  logic       Clock,
	input  logic       Resetn,
	input  logic       go_i,
	input  block_col_t block_col_i,
	input  block_row_t block_row_i,

	output buf_addr_t  buf_addr_a_o,
	output buf_addr_t  buf_addr_b_o,
	input  buf_word_t  buf_rdata_a_i,
	input  buf_word_t  buf_rdata_b_i,

	output sram_addr_t sram_address_o,
	output sram_word_t sram_write_data_o,
	output logic       sram_we_n_o,
	output logic       finished_o
);

store_state_t state;
sram_addr_t out_base;

// pair index is {row, column pair}
logic [4:0] pair;
logic [4:0] pair_d;
logic pair_v;

pixel_t pix_even;
pixel_t pix_odd;

assign buf_addr_a_o = {pair, 1'b0};
assign buf_addr_b_o = {pair, 1'b1};

assign pix_even = buf_rdata_a_i[7:0];
assign pix_odd = buf_rdata_b_i[7:0];

assign sram_write_data_o = {pix_even, pix_odd};
assign sram_address_o = out_base + sram_addr_t'(pair_d[4:2]) * OUT_ROW_STRIDE
	+ sram_addr_t'(pair_d[1:0]);
assign sram_we_n_o = ~pair_v;

always_ff @(posedge Clock or negedge Resetn) begin
	if (!Resetn) begin
		state <= SS_IDLE;
		out_base <= '0;
		pair <= '0;
		pair_d <= '0;
		pair_v <= 1'b0;
		finished_o <= 1'b0;
	end else begin
		// write lags the buffer read by one cycle
		pair_d <= pair;
		pair_v <= (state == SS_READ);
		finished_o <= 1'b0;
		case (state)
			SS_IDLE: begin
				if (go_i) begin
					pair <= '0;
					out_base <= OUT_BASE + {block_row_i, 3'd0} * OUT_ROW_STRIDE
						+ {block_col_i, 2'd0};
					state <= SS_READ;
				end
			end
			SS_READ: begin
				pair <= pair + 5'd1;
				if (pair == 5'd31) begin
					state <= SS_DRAIN;
				end
			end
			SS_DRAIN: begin
				// last word goes out this cycle
				finished_o <= 1'b1;
				state <= SS_IDLE;
			end
			default: state <= SS_IDLE;
		endcase
	end
end

endmodule

//--- design/matrix_pass.sv
// one 8x8 product A*C against the cosine table, scaled and written back transposed; run twice
`timescale 1ns/10ps

module matrix_pass import idct_pkg::*; (
	input  logic      Clock,
	input  logic      Resetn,
	input  logic      go_i,
	input  logic      pass_s_i,

	output buf_addr_t rd_addr_o,
	input  buf_word_t rd_data_i,

	output buf_addr_t wr_addr_o,
	output buf_word_t wr_data_o,
	output logic      wr_en_o,
	output logic      finished_o
);

pass_state_t state;
logic [2:0] row;
logic [2:0] col;
logic [1:0] kstep;
logic [3:0] load_cnt;
logic rd_en;
logic ld_v;
logic last_step;

buf_word_t cur_row [8];
buf_word_t nxt_row [8];

logic signed [47:0] prod0;
logic signed [47:0] prod1;
logic signed [47:0] acc;
logic signed [47:0] acc_next;
logic signed [47:0] scaled;
buf_word_t result;

// row 0 up front, then row r+1 during the first 8 steps of row r
always_comb begin
	rd_en = 1'b0;
	rd_addr_o = {row, load_cnt[2:0]};
	if (state == PS_LOAD) begin
		rd_en = (load_cnt < 4'd8);
	end else if (state == PS_CALC) begin
		rd_addr_o = {row + 3'd1, col[0], kstep};
		rd_en = (row != 3'd7) && (col[2:1] == 2'b00);
	end
end

// k-terms 2*kstep and 2*kstep+1 of column col
assign prod0 = cur_row[0] * COS_TABLE[{kstep, 1'b0, col}];
assign prod1 = cur_row[1] * COS_TABLE[{kstep, 1'b1, col}];

assign acc_next = (kstep == 2'd0) ? (prod0 + prod1) : (acc + prod0 + prod1);
assign scaled = acc_next >>> (pass_s_i ? S_SHIFT : T_SHIFT);
assign last_step = (col == 3'd7) && (kstep == 2'd3);

always_comb begin
	result = scaled[31:0];
	if (pass_s_i) begin
		if (scaled < 0) begin
			result = '0;
		end else if (scaled > 48'sd255) begin
			result = 32'sd255;
		end
	end
end

always_ff @(posedge Clock or negedge Resetn) begin
	if (!Resetn) begin
		state <= PS_IDLE;
		row <= '0;
		col <= '0;
		kstep <= '0;
		load_cnt <= '0;
		ld_v <= 1'b0;
		wr_en_o <= 1'b0;
		finished_o <= 1'b0;
	end else begin
		ld_v <= rd_en;
		wr_en_o <= 1'b0;
		finished_o <= 1'b0;
		case (state)
			PS_IDLE: begin
				if (go_i) begin
					row <= '0;
					col <= '0;
					kstep <= '0;
					load_cnt <= '0;
					state <= PS_LOAD;
				end
			end
			PS_LOAD: begin
				load_cnt <= load_cnt + 4'd1;
				if (load_cnt == 4'd9) begin
					state <= PS_CALC;
				end
			end
			PS_CALC: begin
				kstep <= kstep + 2'd1;
				if (kstep == 2'd3) begin
					wr_en_o <= 1'b1;
					col <= col + 3'd1;
					if (col == 3'd7) begin
						row <= row + 3'd1;
						if (row == 3'd7) begin
							state <= PS_FINISH;
						end
					end
				end
			end
			PS_FINISH: begin
				finished_o <= 1'b1;
				state <= PS_IDLE;
			end
			default: state <= PS_IDLE;
		endcase
	end
end

always_ff @(posedge Clock) begin
	if (ld_v) begin
		for (int i = 0; i < 7; i++) begin
			nxt_row[i] <= nxt_row[i+1];
		end
		nxt_row[7] <= rd_data_i;
	end
	if ((state == PS_LOAD && load_cnt == 4'd9) || (state == PS_CALC && last_step)) begin
		cur_row <= nxt_row;
	end else if (state == PS_CALC) begin
		// rotate by two, back in place after four steps
		for (int i = 0; i < 8; i++) begin
			cur_row[i] <= cur_row[(i + 2) % 8];
		end
	end
	if (state == PS_CALC) begin
		acc <= acc_next;
	end
	if (state == PS_CALC && kstep == 2'd3) begin
		wr_addr_o <= {col, row};
		wr_data_o <= result;
	end
end

endmodule

//--- design/block_fetch.sv
// reads one 8x8 coefficient block from SRAM into buffer 0, started by a go pulse from the top
`timescale 1ns/10ps

module block_fetch import idct_pkg::*; (
	input  logic       Clock,
	input  logic       Resetn,
	input  logic       go_i,
	input  block_col_t block_col_i,
	input  block_row_t block_row_i,

	output sram_addr_t sram_address_o,
	input  sram_word_t sram_read_data_i,

	output buf_addr_t  buf_addr_o,
	output buf_word_t  buf_wdata_o,
	output logic       buf_we_o,
	output logic       finished_o
);

fetch_state_t state;
sram_addr_t row_addr;
buf_addr_t idx;
logic issue;

// index and valid follow the SRAM latency
buf_addr_t idx_pipe [SRAM_READ_LATENCY];
logic [SRAM_READ_LATENCY-1:0] v_pipe;

assign issue = (state == FS_ISSUE);
assign sram_address_o = row_addr + sram_addr_t'(idx[2:0]);

assign buf_addr_o = idx_pipe[SRAM_READ_LATENCY-1];
assign buf_we_o = v_pipe[SRAM_READ_LATENCY-1];
assign buf_wdata_o = {{16{sram_read_data_i[15]}}, sram_read_data_i};

always_ff @(posedge Clock or negedge Resetn) begin
	if (!Resetn) begin
		state <= FS_IDLE;
		row_addr <= '0;
		idx <= '0;
		v_pipe <= '0;
		finished_o <= 1'b0;
	end else begin
		v_pipe <= {v_pipe[SRAM_READ_LATENCY-2:0], issue};
		finished_o <= 1'b0;
		case (state)
			FS_IDLE: begin
				if (go_i) begin
					idx <= '0;
					row_addr <= PRE_IDCT_BASE + {block_row_i, 3'd0} * PRE_ROW_STRIDE
						+ {block_col_i, 3'd0};
					state <= FS_ISSUE;
				end
			end
			FS_ISSUE: begin
				idx <= idx + 6'd1;
				// next image row of the block
				if (idx[2:0] == 3'd7) begin
					row_addr <= row_addr + PRE_ROW_STRIDE;
				end
				if (idx == 6'd63) begin
					state <= FS_DRAIN;
				end
			end
			FS_DRAIN: begin
				if (buf_we_o && buf_addr_o == 6'd63) begin
					finished_o <= 1'b1;
					state <= FS_IDLE;
				end
			end
			default: state <= FS_IDLE;
		endcase
	end
end

always_ff @(posedge Clock) begin
	idx_pipe[0] <= idx;
	for (int i = 1; i < SRAM_READ_LATENCY; i++) begin
		idx_pipe[i] <= idx_pipe[i-1];
	end
end

endmodule

//--- design/dp_ram.sv
// 64 x 32 dual-port block buffer with registered reads, holds one 8x8 matrix between passes
`timescale 1ns/10ps

module dp_ram import idct_pkg::*; (
	input  logic      Clock,

	input  buf_addr_t addr_a_i,
	input  buf_word_t wdata_a_i,
	input  logic      we_a_i,
	output buf_word_t rdata_a_o,

	input  buf_addr_t addr_b_i,
	input  buf_word_t wdata_b_i,
	input  logic      we_b_i,
	output buf_word_t rdata_b_o
);

buf_word_t mem [BUF_DEPTH];

// read returns old contents on a same-address write
always_ff @(posedge Clock) begin
	if (we_a_i) begin
		mem[addr_a_i] <= wdata_a_i;
	end
	if (we_b_i) begin
		mem[addr_b_i] <= wdata_b_i;
	end
	rdata_a_o <= mem[addr_a_i];
	rdata_b_o <= mem[addr_b_i];
end

endmodule

//--- design/idct_pkg.sv
// shared widths, address map, cosine table and FSM encodings, imported by every IDCT block
package idct_pkg;

	// SRAM side
	typedef logic [17:0] sram_addr_t;
	typedef logic [15:0] sram_word_t;

	// block buffer side, row-major 8x8
	typedef logic [5:0] buf_addr_t;
	typedef logic signed [31:0] buf_word_t;

	typedef logic signed [15:0] coeff_t;
	typedef logic [7:0] pixel_t;

	// block position in the luma plane
	typedef logic [5:0] block_col_t;
	typedef logic [4:0] block_row_t;

	localparam int BUF_DEPTH = 64;

	localparam sram_addr_t PRE_IDCT_BASE = 18'd76800;
	localparam sram_addr_t PRE_ROW_STRIDE = 18'd320;
	localparam sram_addr_t OUT_BASE = 18'd0;
	localparam sram_addr_t OUT_ROW_STRIDE = 18'd160;

	localparam int SRAM_READ_LATENCY = 2;

	localparam int T_SHIFT = 8;
	localparam int S_SHIFT = 16;

	// C[k][c] at index 8k+c, scaled by 4096
	localparam coeff_t COS_TABLE [64] = '{
		1448,  2009,  1892,  1703,  1448,  1138,   784,   400,
		1448,  1703,   784,  -400, -1448, -2009, -1892, -1138,
		1448,  1138,  -784, -2009, -1448,   400,  1892,  1703,
		1448,   400, -1892, -1138,  1448,  1703,  -784, -2009,
		1448,  -400, -1892,  1138,  1448, -1703,  -784,  2009,
		1448, -1138,  -784,  2009, -1448,  -400,  1892, -1703,
		1448, -1703,   784,   400, -1448,  2009, -1892,  1138,
		1448, -2009,  1892, -1703,  1448, -1138,   784,  -400
	};

	// top level phases
	typedef enum logic [2:0] {
		IDLE,
		FETCH,
		PASS_T,
		PASS_S,
		STORE
	} top_state_t;

	typedef enum logic [1:0] {FS_IDLE, FS_ISSUE, FS_DRAIN} fetch_state_t;

	typedef enum logic [1:0] {PS_IDLE, PS_LOAD, PS_CALC, PS_FINISH} pass_state_t;

	typedef enum logic [1:0] {SS_IDLE, SS_READ, SS_DRAIN} store_state_t;

endpackage
